//--- design/cla_pkg.sv
`default_nettype none

// ==========================================================================
// Shared types for the pipelined carry lookahead adder
// ==========================================================================

package cla_pkg;

	// Operation select
	// Subtract forms are x minus y with y inverted in the operand stage
	typedef enum logic [1:0] {
		OP_ADD = 2'b00,
		OP_ADC = 2'b01,
		OP_SUB = 2'b10,
		OP_SBC = 2'b11
	} op_t;

	// One carry status pair
	// Bit 1 is the carry column and bit 0 the sum column
	typedef logic [1:0] cs_t;

	// Status codes emitted by the prefix merge
	// Kill blocks any carry coming from below
	localparam cs_t CS_KILL = 2'b00;
	// Propagate passes the lower status through
	localparam cs_t CS_PROP = 2'b01;
	// Generate produces a carry on its own
	localparam cs_t CS_GEN  = 2'b11;

	// Code 10 only shows up on raw input symbols
	// It comes from a position whose AND bit is set, or from carry-in at position 0
	// The merge decodes it by its carry bit and never emits it

	// Result flags registered with the sum
	typedef struct packed {
		// Carry out of the MSB, or no borrow for subtract
		logic carry;
		// Signed overflow
		logic overflow;
		// Result is all zero
		logic zero;
		// Copy of the result MSB
		logic negative;
	} flags_t;

endpackage

`default_nettype wire

//--- design/cla_operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

// ==========================================================================
// Operand stage
// Decodes the operation and registers the position status vectors
// ==========================================================================

module cla_operand_stage #(
	parameter int width = 32
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  cla_pkg::op_t         op,
	input  logic [width-1:0]     x,
	input  logic [width-1:0]     y,
	input  logic                 carry_in,
	output logic                 stage_valid,
	output logic [width:0]       sym_carry,
	output logic [width:0]       sym_sum
);

	// Operand word and status vector with carry-in at position 0
	typedef logic [width-1:0] word_t;
	typedef logic [width:0]   sym_t;

	logic  invert_y;
	logic  carry_eff;
	word_t y_cond;
	sym_t  carry_next;
	sym_t  sum_next;

	// Operation decode
	always_comb begin
		invert_y  = 1'b0;
		carry_eff = 1'b0;
		unique case (op)
			cla_pkg::OP_ADD: begin
				invert_y  = 1'b0;
				carry_eff = 1'b0;
			end
			cla_pkg::OP_ADC: begin
				invert_y  = 1'b0;
				carry_eff = carry_in;
			end
			// Two's complement negate of y
			cla_pkg::OP_SUB: begin
				invert_y  = 1'b1;
				carry_eff = 1'b1;
			end
			// carry_in high means no borrow
			cla_pkg::OP_SBC: begin
				invert_y  = 1'b1;
				carry_eff = carry_in;
			end
		endcase
	end

	assign y_cond = invert_y ? ~y : y;

	// Position j holds the status of bit j-1
	// Position 0 is the effective carry-in with an empty sum column
	assign carry_next = {x & y_cond, carry_eff};
	assign sum_next   = {x ^ y_cond, 1'b0};

	// Stage valid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= in_valid;
		end
	end

	// Symbol registers load only with a valid operation
	always_ff @(posedge clk) begin
		if (in_valid) begin
			sym_carry <= carry_next;
			sym_sum   <= sum_next;
		end
	end

endmodule

`default_nettype wire

//--- design/cla_prefix_resolver.sv
`timescale 1ns/1ps
`default_nettype none

// ==========================================================================
// Parallel-prefix carry status resolver
// One merge level per instance, block size doubles at each level
// Depth grows as log2 of width
// ==========================================================================

module cla_prefix_resolver #(
	// Number of status positions, carry-in included
	parameter int width      = 2,
	// Block size merged at this level
	parameter int block_size = 1
) (
	input  logic [width-1:0] carry,
	input  logic [width-1:0] sum,
	output logic [width-1:0] resolved
);

	// Status merge
	//              | k p g  <- input
	//           ---+------
	//   state  k   | k k g
	//          p   | k p g
	//          g   | k g g
	// Input kill or generate overrides, input propagate passes the state
	function automatic cla_pkg::cs_t cs_merge(
		input cla_pkg::cs_t state,
		input cla_pkg::cs_t in_cs
	);
		cla_pkg::cs_t next_cs;
		if (in_cs[1]) begin
			// Carry column set means generate
			next_cs = cla_pkg::CS_GEN;
		end else if (in_cs[0]) begin
			// Propagate takes the lower status
			if (state[1]) begin
				next_cs = cla_pkg::CS_GEN;
			end else if (state[0]) begin
				next_cs = cla_pkg::CS_PROP;
			end else begin
				next_cs = cla_pkg::CS_KILL;
			end
		end else begin
			next_cs = cla_pkg::CS_KILL;
		end
		return next_cs;
	endfunction

	// Status vectors after this level
	logic [width-1:0] level_carry;
	logic [width-1:0] level_sum;

	// ======================================================================
	// Merge level
	// ======================================================================

	for (genvar i = 0; i < width; i++) begin : g_pos
		// Block of this position and the top position of the block below
		localparam int block_idx = i / block_size;
		localparam int state_idx = block_idx * block_size - 1;

		if ((block_idx % 2) == 0) begin : g_pass
			// Even blocks are already resolved up to this level
			assign level_carry[i] = carry[i];
			assign level_sum[i]   = sum[i];
		end else begin : g_merge
			cla_pkg::cs_t merged;

			// Odd blocks take the status of the last even position below
			assign merged = cs_merge({carry[state_idx], sum[state_idx]},
				{carry[i], sum[i]});
			assign level_carry[i] = merged[1];
			assign level_sum[i]   = merged[0];
		end
	end

	// ======================================================================
	// Next level or end of recursion
	// ======================================================================

	if ((2 * block_size) >= width) begin : g_last
		// Every position now sees position 0
		// The carry column is the carry into each bit
		assign resolved = level_carry;
	end else begin : g_next
		cla_prefix_resolver #(
			.width      (width),
			.block_size (2 * block_size)
		) u_next_level (
			.carry    (level_carry),
			.sum      (level_sum),
			.resolved (resolved)
		);
	end

endmodule

`default_nettype wire

//--- design/cla_result_stage.sv
`timescale 1ns/1ps
`default_nettype none

// ==========================================================================
// Result stage
// Sum formation, flag logic and output registers
// ==========================================================================

module cla_result_stage #(
	parameter int width = 32
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stage_valid,
	input  logic [width:0]       sym_sum,
	input  logic [width:0]       resolved,
	output logic                 out_valid,
	output logic [width-1:0]     result,
	output cla_pkg::flags_t      flags
);

	typedef logic [width-1:0] word_t;

	word_t           half_sum;
	word_t           carry_into;
	word_t           sum_next;
	cla_pkg::flags_t flags_next;

	// Half sum of bit i sits at status position i+1
	assign half_sum = sym_sum[width:1];

	// Carry into bit i is the resolved carry at position i
	assign carry_into = resolved[width-1:0];

	assign sum_next = half_sum ^ carry_into;

	// ======================================================================
	// Flags
	// ======================================================================

	always_comb begin
		// Carry out of the top bit
		flags_next.carry    = resolved[width];
		// Carry into the MSB differs from carry out
		flags_next.overflow = resolved[width] ^ resolved[width-1];
		flags_next.zero     = (sum_next == '0);
		flags_next.negative = sum_next[width-1];
	end

	// ======================================================================
	// Output registers
	// ======================================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= stage_valid;
		end
	end

	// Result and flags hold between valid pulses
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result <= '0;
			flags  <= '0;
		end else if (stage_valid) begin
			result <= sum_next;
			flags  <= flags_next;
		end
	end

endmodule

`default_nettype wire

//--- design/cla_adder_top.sv
`timescale 1ns/1ps
`default_nettype none

// ==========================================================================
// Pipelined carry lookahead adder
// Two clock latency, one operation per clock
// ==========================================================================

module cla_adder_top #(
	parameter int width = 32
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  cla_pkg::op_t         op,
	input  logic [width-1:0]     x,
	input  logic [width-1:0]     y,
	input  logic                 carry_in,
	output logic                 out_valid,
	output logic [width-1:0]     result,
	output cla_pkg::flags_t      flags
);

	// Registered status vectors and their resolved carries
	logic             stage_valid;
	logic [width:0]   sym_carry;
	logic [width:0]   sym_sum;
	logic [width:0]   resolved;

	// First clock
	cla_operand_stage #(
		.width (width)
	) u_operand_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.op          (op),
		.x           (x),
		.y           (y),
		.carry_in    (carry_in),
		.stage_valid (stage_valid),
		.sym_carry   (sym_carry),
		.sym_sum     (sym_sum)
	);

	// Combinational tree between the two register stages
	// Carry-in position makes it one wider than the operands
	cla_prefix_resolver #(
		.width (width + 1)
	) u_prefix_resolver (
		.carry    (sym_carry),
		.sum      (sym_sum),
		.resolved (resolved)
	);

	// Second clock
	cla_result_stage #(
		.width (width)
	) u_result_stage (
		.clk         (clk),
		.rst_n       (rst_n),
		.stage_valid (stage_valid),
		.sym_sum     (sym_sum),
		.resolved    (resolved),
		.out_valid   (out_valid),
		.result      (result),
		.flags       (flags)
	);

endmodule

`default_nettype wire

//--- dv/cla_adder_properties.sv
`timescale 1ns/1ps
`default_nettype none

module cla_adder_properties #(
	parameter int width = 32
) (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 in_valid,
	input logic                 out_valid,
	input logic [width-1:0]     result,
	input cla_pkg::flags_t      flags
);

	// No output while reset is held
	a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else $error("out_valid high during reset");

	// Fixed two clock latency
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, 2))
		else $error("out_valid does not follow in_valid by two cycles");

	// Zero flag matches the result
	a_zero_flag: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (flags.zero == (result == '0)))
		else $error("zero flag disagrees with result");

	// Negative flag is the MSB, also while holding
	a_negative_flag: assert property (@(posedge clk) disable iff (!rst_n)
		flags.negative == result[width-1])
		else $error("negative flag disagrees with result MSB");

endmodule

bind cla_adder_top cla_adder_properties #(
	.width (width)
) u_properties (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.result    (result),
	.flags     (flags)
);

`default_nettype wire

//--- dv/cla_adder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cla_adder_tb;

	localparam int width = 13;
	// Directed, random and gap phases take about 650 cycles with drain
	localparam int max_cycles = 1200;

	typedef logic [width-1:0] word_t;

	// Expected response of one operation
	typedef struct packed {
		word_t           result;
		cla_pkg::flags_t flags;
	} expect_t;

	logic            clk;
	logic            rst_n;
	logic            in_valid;
	cla_pkg::op_t    op;
	word_t           x;
	word_t           y;
	logic            carry_in;
	logic            out_valid;
	word_t           result;
	cla_pkg::flags_t flags;

	// Expectations in issue order
	expect_t         pending[$];
	int              seed;
	int              cycle_count = 0;
	int              checked = 0;
	// Last output, for the hold check between pulses
	logic            have_output = 1'b0;
	word_t           held_result;
	cla_pkg::flags_t held_flags;

	cla_adder_top #(
		.width (width)
	) dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.x         (x),
		.y         (y),
		.carry_in  (carry_in),
		.out_valid (out_valid),
		.result    (result),
		.flags     (flags)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==========================================================================
	// Reference model and checks
	// ==========================================================================

	// Add forms sum with carry out, subtract forms take a borrow
	function automatic expect_t reference_model(cla_pkg::op_t r_op, word_t a, word_t b,
		logic c);
		logic [width:0] wide;
		logic           is_sub;
		logic           cin;
		expect_t        e;
		is_sub = (r_op == cla_pkg::OP_SUB) || (r_op == cla_pkg::OP_SBC);
		// Carry-in for add forms, no-borrow flag for subtract forms
		cin = (r_op == cla_pkg::OP_ADC || r_op == cla_pkg::OP_SBC) ? c : is_sub;
		if (is_sub) begin
			wide = {1'b0, a} - {1'b0, b} - {{width{1'b0}}, ~cin};
			// Carry set means no borrow out
			e.flags.carry    = ~wide[width];
			e.flags.overflow = (a[width-1] != b[width-1]) && (wide[width-1] != a[width-1]);
		end else begin
			wide = {1'b0, a} + {1'b0, b} + {{width{1'b0}}, cin};
			e.flags.carry    = wide[width];
			e.flags.overflow = (a[width-1] == b[width-1]) && (wide[width-1] != a[width-1]);
		end
		e.result         = wide[width-1:0];
		e.flags.zero     = (wide[width-1:0] == '0);
		e.flags.negative = wide[width-1];
		return e;
	endfunction

	task automatic stop_with_failure();
		$display("RESULT: FAIL");
		$fatal(1, "Run stopped after the first failure");
	endtask

	task automatic check_result(input word_t got, input word_t want);
		if (got !== want) begin
			$display("[ERROR] %0t ns: result is %h, expected %h", $time, got, want);
			stop_with_failure();
		end
	endtask

	task automatic check_flags(input cla_pkg::flags_t got, input cla_pkg::flags_t want);
		if (got !== want) begin
			$display("[ERROR] %0t ns: flags c/v/z/n are %b, expected %b", $time, got, want);
			stop_with_failure();
		end
	endtask

	// Outputs compared at the falling edge where they are settled
	always @(negedge clk) begin
		expect_t e;
		if (!rst_n && out_valid) begin
			$display("out_valid went high while reset was held");
			stop_with_failure();
		end else if (out_valid) begin
			if (pending.size() == 0) begin
				$display("out_valid went high with no operation outstanding");
				stop_with_failure();
			end else begin
				e = pending.pop_front();
				check_result(result, e.result);
				check_flags(flags, e.flags);
				held_result = result;
				held_flags  = flags;
				have_output = 1'b1;
				checked++;
			end
		end else if (have_output) begin
			// Outputs hold while out_valid is low
			check_result(result, held_result);
			check_flags(flags, held_flags);
		end
	end

	// Run limit
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", max_cycles);
			stop_with_failure();
		end
	end

	// ==========================================================================
	// Stimulus
	// ==========================================================================

	task automatic issue(cla_pkg::op_t i_op, word_t a, word_t b, logic c);
		@(posedge clk);
		in_valid <= 1'b1;
		op       <= i_op;
		x        <= a;
		y        <= b;
		carry_in <= c;
		pending.push_back(reference_model(i_op, a, b, c));
	endtask

	task automatic idle_cycles(int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	task automatic issue_random();
		logic [31:0] r_op;
		logic [31:0] r_x;
		logic [31:0] r_y;
		r_op = $random(seed);
		r_x  = $random(seed);
		r_y  = $random(seed);
		issue(cla_pkg::op_t'(r_op[1:0]), r_x[width-1:0], r_y[width-1:0], r_op[4]);
	endtask

	// Alternating bits, LSB set
	function automatic word_t alternating();
		word_t w;
		for (int i = 0; i < width; i++) begin
			w[i] = ~i[0];
		end
		return w;
	endfunction

	// Corner cases, eight per operation
	task automatic run_directed();
		word_t all_ones;
		word_t max_pos;
		word_t min_neg;
		word_t alt;
		word_t prop_y;
		all_ones = '1;
		max_pos  = {1'b0, {(width-1){1'b1}}};
		min_neg  = {1'b1, {(width-1){1'b0}}};
		alt      = alternating();
		for (int k = 0; k < 4; k++) begin
			// Subtract inverts y, so y equal to x makes every position propagate
			prop_y = (k < 2) ? ~alt : alt;
			issue(cla_pkg::op_t'(k[1:0]), '0, '0, 1'b0);
			issue(cla_pkg::op_t'(k[1:0]), all_ones, word_t'(1), 1'b1);
			issue(cla_pkg::op_t'(k[1:0]), max_pos, max_pos, 1'b1);
			issue(cla_pkg::op_t'(k[1:0]), max_pos, word_t'(1), 1'b0);
			issue(cla_pkg::op_t'(k[1:0]), min_neg, word_t'(1), 1'b1);
			issue(cla_pkg::op_t'(k[1:0]), all_ones, '0, 1'b1);
			issue(cla_pkg::op_t'(k[1:0]), alt, prop_y, 1'b0);
			issue(cla_pkg::op_t'(k[1:0]), alt, prop_y, 1'b1);
		end
		idle_cycles(3);
	endtask

	task automatic run_with_gaps(int count);
		logic [31:0] r;
		for (int n = 0; n < count; n++) begin
			issue_random();
			r = $random(seed);
			// Gap of 0 to 2 idle cycles
			idle_cycles(int'(r[1:0]) % 3);
		end
	endtask

	// Full-length carry chains across the uneven tree split
	task automatic run_carry_chain();
		word_t alt;
		alt = alternating();
		for (int c = 0; c < 2; c++) begin
			issue(cla_pkg::OP_ADC, alt, ~alt, c[0]);
			issue(cla_pkg::OP_ADC, ~alt, alt, c[0]);
			issue(cla_pkg::OP_SBC, alt, alt, c[0]);
			issue(cla_pkg::OP_SBC, ~alt, ~alt, c[0]);
		end
	endtask

	initial begin
		seed     = 32'h01e62775;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		op       = cla_pkg::OP_ADD;
		x        = '0;
		y        = '0;
		carry_in = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		// Quiet cycles before the first operation
		idle_cycles(3);
		run_directed();
		for (int n = 0; n < 400; n++) begin
			issue_random();
		end
		idle_cycles(2);
		run_with_gaps(100);
		run_carry_chain();
		idle_cycles(1);
		// Drain, then a few extra cycles to catch a stray pulse
		for (int i = 0; i < 8 && pending.size() != 0; i++) begin
			@(posedge clk);
		end
		repeat (4) @(posedge clk);
		if (pending.size() == 0) begin
			$display("Checked %0d operations", checked);
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("%0d operations never produced an output", pending.size());
			stop_with_failure();
		end
	end

endmodule

`default_nettype wire

//--- all.f
design/cla_pkg.sv
design/cla_operand_stage.sv
design/cla_prefix_resolver.sv
design/cla_result_stage.sv
design/cla_adder_top.sv
dv/cla_adder_properties.sv
dv/cla_adder_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the adder testbench with Verilator
cd "$(dirname "$0")" || exit 1

output=""
verilator --binary --timing --assert -f all.f --top-module cla_adder_tb -o cla_adder_sim \
	&& output="$(./obj_dir/cla_adder_sim 2>&1)" \
	|| { echo "$output"; echo "Build or simulation failed"; exit 1; }

echo "$output"
echo "$output" | grep -qx "RESULT: PASS" && exit 0 || exit 1
